// ==== tb.f ====
src/dcache_pkg.sv
src/dcache_d0.sv
src/dcache_array.sv
src/dcache_d1.sv
src/dcache.sv
dv/tb_clkgen.sv
dv/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - files:
      - src/dcache_pkg.sv
      - src/dcache_d0.sv
      - src/dcache_array.sv
      - src/dcache_d1.sv
      - src/dcache.sv
  - target: test
    files:
      - dv/tb_clkgen.sv
      - dv/dcache_tb.sv

// ==== dv/dcache_tb.sv ====
// Data cache random testbench
`timescale 1ns/1ps

module dcache_tb;

    import dcache_pkg::*;

    localparam int NUM_CYCLES    = 2000;
    localparam int WARMUP_LOADS  = 16;
    localparam int ACK_LATENCY   = 2;
    localparam int ACK_TIMEOUT   = 10;
    localparam int RESET_TIMEOUT = 40;

    typedef struct packed {
        logic [31:0] cyc;
        logic        hit;
        logic        line_valid;
        logic        line_dirty;
        dc_data_t    data;
        dc_addr_t    victim_addr;
        dc_line_t    victim_data;
    } expect_t;

    logic         clk;
    logic         n_rst;
    logic         i_req;
    dc_op_t       i_op;
    dc_addr_t     i_addr;
    dc_byte_sel_t i_byte_sel;
    dc_data_t     i_data;
    dc_line_t     i_fill_data;
    logic         o_ack;
    logic         o_hit;
    dc_data_t     o_data;
    logic         o_victim_valid;
    logic         o_victim_dirty;
    dc_addr_t     o_victim_addr;
    dc_line_t     o_victim_data;

    // Reference model, one entry per set with the line kept as bytes
    logic         mdl_valid [DC_NUM_SETS];
    logic         mdl_dirty [DC_NUM_SETS];
    dc_tag_t      mdl_tag   [DC_NUM_SETS];
    logic [7:0]   mdl_byte  [DC_NUM_SETS][DC_LINE_SIZE];

    expect_t      exp_q [$];
    integer       seed;
    int           cycle;
    int           errors;
    int           requests;
    int           load_hits;
    int           store_hits;
    int           dirty_evicts;
    int           same_set_b2b;
    logic         timed_out;

    tb_clkgen u_clkgen (
        .o_clk   (clk),
        .o_n_rst (n_rst)
    );

    dcache UUT (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_req          (i_req),
        .i_op           (i_op),
        .i_addr         (i_addr),
        .i_byte_sel     (i_byte_sel),
        .i_data         (i_data),
        .i_fill_data    (i_fill_data),
        .o_ack          (o_ack),
        .o_hit          (o_hit),
        .o_data         (o_data),
        .o_victim_valid (o_victim_valid),
        .o_victim_dirty (o_victim_dirty),
        .o_victim_addr  (o_victim_addr),
        .o_victim_data  (o_victim_data)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Three tags over four sets keep hits and conflicts frequent
    function automatic dc_tag_t pick_tag(input logic [1:0] k);
        case (k)
            2'd0:    return 24'h00a5c3;
            2'd1:    return 24'h13f00d;
            default: return 24'h7e0b21;
        endcase
    endfunction

    function automatic dc_index_t pick_index(input logic [1:0] k);
        case (k)
            2'd0:    return 4'h0;
            2'd1:    return 4'h5;
            2'd2:    return 4'ha;
            default: return 4'hf;
        endcase
    endfunction

    function automatic dc_line_t model_line(input dc_index_t idx);
        dc_line_t line;
        for (int k = 0; k < DC_LINE_SIZE; k++) begin
            line[k*8 +: 8] = mdl_byte[idx][k];
        end
        return line;
    endfunction

    // Selected bytes from the offset on, nothing past the last byte of the line
    function automatic dc_data_t model_load(input dc_index_t idx, input dc_offset_t off,
                                            input dc_byte_sel_t sel);
        dc_data_t word;
        word = '0;
        for (int j = 0; j < DC_WORD_SIZE; j++) begin
            if (sel[j] && int'(off) + j < DC_LINE_SIZE) begin
                word[j*8 +: 8] = mdl_byte[idx][int'(off) + j];
            end
        end
        return word;
    endfunction

    task automatic value_error(input string name, input logic [DC_LINE_WIDTH-1:0] got,
                               input logic [DC_LINE_WIDTH-1:0] exp);
        errors++;
        $display("ERROR %s got 0x%0h expected 0x%0h at %0d ns", name, got, exp, $time);
    endtask

    // Predicts the response from the model state, then updates the model and drives the DUT
    task automatic issue_request(input dc_op_t op, input dc_index_t idx);
        logic [31:0]  rnd;
        dc_tag_t      tag;
        dc_offset_t   off;
        dc_byte_sel_t sel;
        dc_data_t     data;
        dc_line_t     fill;
        expect_t      e;

        rnd  = $random(seed);
        tag  = pick_tag(rnd[1:0]);
        off  = rnd[7:4];
        sel  = rnd[11:8];
        data = $random(seed);
        for (int w = 0; w < DC_LINE_WIDTH / DC_DATA_WIDTH; w++) begin
            fill[w*32 +: 32] = $random(seed);
        end

        e.cyc         = cycle + 1;
        e.hit         = mdl_valid[idx] && mdl_tag[idx] == tag;
        e.line_valid  = mdl_valid[idx];
        e.line_dirty  = mdl_dirty[idx];
        e.data        = model_load(idx, off, sel);
        e.victim_addr = {mdl_tag[idx], idx, {DC_OFFSET_WIDTH{1'b0}}};
        e.victim_data = model_line(idx);
        exp_q.push_back(e);
        requests++;

        if (op == DC_OP_LOAD && e.hit) begin
            load_hits++;
        end
        if (op == DC_OP_FILL) begin
            if (e.line_valid && e.line_dirty && !e.hit) begin
                dirty_evicts++;
            end
            mdl_valid[idx] = 1'b1;
            mdl_dirty[idx] = 1'b0;
            mdl_tag[idx]   = tag;
            for (int k = 0; k < DC_LINE_SIZE; k++) begin
                mdl_byte[idx][k] = fill[k*8 +: 8];
            end
        end else if (op == DC_OP_STORE && e.hit) begin
            store_hits++;
            mdl_dirty[idx] = 1'b1;
            for (int j = 0; j < DC_WORD_SIZE; j++) begin
                if (sel[j] && int'(off) + j < DC_LINE_SIZE) begin
                    mdl_byte[idx][int'(off) + j] = data[j*8 +: 8];
                end
            end
        end

        i_req       <= 1'b1;
        i_op        <= op;
        i_addr      <= {tag, idx, off};
        i_byte_sel  <= sel;
        i_data      <= data;
        i_fill_data <= fill;
    endtask

    // Each acknowledge retires the oldest prediction
    initial begin : monitor
        expect_t e;
        forever begin
            @(negedge clk);
            if (o_ack === 1'b1) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Acknowledge with no request outstanding at %0d ns", $time);
                end else begin
                    e = exp_q.pop_front();
                    if (cycle != e.cyc + ACK_LATENCY) begin
                        errors++;
                        $display("Acknowledge in cycle %0d for request of cycle %0d, not %0d later",
                                 cycle, e.cyc, ACK_LATENCY);
                    end
                    if (o_hit !== e.hit) value_error("o_hit", o_hit, e.hit);
                    if (o_victim_valid !== e.line_valid) begin
                        value_error("o_victim_valid", o_victim_valid, e.line_valid);
                    end
                    // Data and victim fields are only defined once the set holds a line
                    if (e.line_valid) begin
                        if (o_data !== e.data) value_error("o_data", o_data, e.data);
                        if (o_victim_dirty !== e.line_dirty) begin
                            value_error("o_victim_dirty", o_victim_dirty, e.line_dirty);
                        end
                        if (o_victim_addr !== e.victim_addr) begin
                            value_error("o_victim_addr", o_victim_addr, e.victim_addr);
                        end
                        if (o_victim_data !== e.victim_data) begin
                            value_error("o_victim_data", o_victim_data, e.victim_data);
                        end
                    end
                end
            end
            if (!timed_out && exp_q.size() > 0 && cycle > exp_q[0].cyc + ACK_TIMEOUT) begin
                errors++;
                timed_out = 1'b1;
                $display("No acknowledge within %0d cycles for the request of cycle %0d",
                         ACK_TIMEOUT, exp_q[0].cyc);
            end
        end
    end

    initial begin : stimulus
        logic [31:0] rnd;
        dc_op_t      op;
        dc_index_t   idx;
        dc_index_t   last_idx;
        logic        last_req;
        int          waited;

        i_req        = 1'b0;
        i_op         = DC_OP_LOAD;
        i_addr       = '0;
        i_byte_sel   = '0;
        i_data       = '0;
        i_fill_data  = '0;
        seed         = 32'hc5ea;
        cycle        = 0;
        errors       = 0;
        requests     = 0;
        load_hits    = 0;
        store_hits   = 0;
        dirty_evicts = 0;
        same_set_b2b = 0;
        timed_out    = 1'b0;
        last_idx     = '0;
        last_req     = 1'b0;
        for (int s = 0; s < DC_NUM_SETS; s++) begin
            mdl_valid[s] = 1'b0;
            mdl_dirty[s] = 1'b0;
            mdl_tag[s]   = '0;
            for (int k = 0; k < DC_LINE_SIZE; k++) begin
                mdl_byte[s][k] = 8'h00;
            end
        end

        for (waited = 0; waited < RESET_TIMEOUT && n_rst !== 1'b1; waited++) begin
            @(posedge clk);
        end
        if (n_rst !== 1'b1) begin
            errors++;
            timed_out = 1'b1;
            $display("Reset was never released");
        end

        // Loads only at first, so the empty cache must miss everywhere
        for (int n = 0; n < NUM_CYCLES && !timed_out; n++) begin
            @(posedge clk);
            rnd = $random(seed);
            if (rnd[4:0] < 5'd6) begin
                i_req <= 1'b0;
                last_req = 1'b0;
            end else begin
                rnd = $random(seed);
                if (n < WARMUP_LOADS || rnd % 100 < 45) begin
                    op = DC_OP_LOAD;
                end else if (rnd % 100 < 80) begin
                    op = DC_OP_STORE;
                end else begin
                    op = DC_OP_FILL;
                end
                idx = pick_index(rnd[9:8]);
                if (last_req && idx == last_idx) begin
                    same_set_b2b++;
                end
                issue_request(op, idx);
                last_req = 1'b1;
                last_idx = idx;
            end
        end

        @(posedge clk);
        i_req <= 1'b0;
        for (waited = 0; waited < ACK_TIMEOUT && exp_q.size() > 0; waited++) begin
            @(posedge clk);
        end
        if (exp_q.size() > 0 && !timed_out) begin
            errors++;
            $display("%0d requests were never acknowledged", exp_q.size());
        end
        if (load_hits == 0 || store_hits == 0 || dirty_evicts == 0 || same_set_b2b == 0) begin
            errors++;
            $display("Random stimulus missed hits, store hits, dirty victims or same set pairs");
        end

        $display("reqs %0d load hits %0d store hits %0d dirty evicts %0d b2b %0d errors %0d",
                 requests, load_hits, store_hits, dirty_evicts, same_set_b2b, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== dv/tb_clkgen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clkgen (
    output logic o_clk,
    output logic o_n_rst
);

    localparam int RESET_CYCLES = 16;

    // 4 ns period
    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;
    end

    initial begin
        o_n_rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_n_rst <= 1'b1;
    end

endmodule

// ==== src/dcache.sv ====
// Data cache pipeline top
`timescale 1ns/1ps

module dcache (
    input  logic                     clk,
    input  logic                     n_rst,

    input  logic                     i_req,
    input  dcache_pkg::dc_op_t       i_op,
    input  dcache_pkg::dc_addr_t     i_addr,
    input  dcache_pkg::dc_byte_sel_t i_byte_sel,
    input  dcache_pkg::dc_data_t     i_data,
    input  dcache_pkg::dc_line_t     i_fill_data,

    output logic                     o_ack,
    output logic                     o_hit,
    output dcache_pkg::dc_data_t     o_data,
    output logic                     o_victim_valid,
    output logic                     o_victim_dirty,
    output dcache_pkg::dc_addr_t     o_victim_addr,
    output dcache_pkg::dc_line_t     o_victim_data
);

    import dcache_pkg::*;

    dc_index_t    rd_index;

    // Request fields registered by d0
    logic         d0_req;
    logic         d0_wr_en;
    logic         d0_fill;
    dc_tag_t      d0_tag;
    dc_index_t    d0_index;
    dc_offset_t   d0_offset;
    dc_byte_sel_t d0_byte_sel;
    dc_data_t     d0_data;
    logic         d0_valid;
    logic         d0_dirty;
    dc_line_t     d0_fill_data;

    // Array read results
    logic         rd_valid;
    logic         rd_dirty;
    dc_tag_t      rd_tag;
    dc_line_t     rd_data;

    // d1 write, which also loops back as the d1 bypass
    logic         wr_en;
    dc_index_t    wr_index;
    dc_tag_t      wr_tag;
    dc_line_t     wr_data;
    logic         wr_valid;
    logic         wr_dirty;

    dcache_d0 u_d0 (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_req       (i_req),
        .i_op        (i_op),
        .i_addr      (i_addr),
        .i_byte_sel  (i_byte_sel),
        .i_data      (i_data),
        .i_fill_data (i_fill_data),
        .o_rd_index  (rd_index),
        .o_req       (d0_req),
        .o_wr_en     (d0_wr_en),
        .o_fill      (d0_fill),
        .o_tag       (d0_tag),
        .o_index     (d0_index),
        .o_offset    (d0_offset),
        .o_byte_sel  (d0_byte_sel),
        .o_data      (d0_data),
        .o_valid     (d0_valid),
        .o_dirty     (d0_dirty),
        .o_fill_data (d0_fill_data)
    );

    dcache_array u_array (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_rd_index (rd_index),
        .i_wr_en    (wr_en),
        .i_wr_index (wr_index),
        .i_wr_tag   (wr_tag),
        .i_wr_data  (wr_data),
        .i_wr_valid (wr_valid),
        .i_wr_dirty (wr_dirty),
        .o_rd_valid (rd_valid),
        .o_rd_dirty (rd_dirty),
        .o_rd_tag   (rd_tag),
        .o_rd_data  (rd_data)
    );

    dcache_d1 u_d1 (
        .clk                     (clk),
        .n_rst                   (n_rst),
        .i_req                   (d0_req),
        .i_wr_en                 (d0_wr_en),
        .i_tag                   (d0_tag),
        .i_index                 (d0_index),
        .i_offset                (d0_offset),
        .i_byte_sel              (d0_byte_sel),
        .i_data                  (d0_data),
        .i_valid                 (d0_valid),
        .i_dirty                 (d0_dirty),
        .i_fill                  (d0_fill),
        .i_fill_data             (d0_fill_data),
        .i_cache_rd_valid        (rd_valid),
        .i_cache_rd_dirty        (rd_dirty),
        .i_cache_rd_tag          (rd_tag),
        .i_cache_rd_data         (rd_data),
        .i_bypass_cache_wr_en    (wr_en),
        .i_bypass_cache_wr_index (wr_index),
        .i_bypass_cache_wr_tag   (wr_tag),
        .i_bypass_cache_wr_data  (wr_data),
        .i_bypass_cache_wr_valid (wr_valid),
        .i_bypass_cache_wr_dirty (wr_dirty),
        .o_cache_wr_en           (wr_en),
        .o_cache_wr_index        (wr_index),
        .o_cache_wr_tag          (wr_tag),
        .o_cache_wr_data         (wr_data),
        .o_cache_wr_valid        (wr_valid),
        .o_cache_wr_dirty        (wr_dirty),
        .o_ack                   (o_ack),
        .o_hit                   (o_hit),
        .o_data                  (o_data),
        .o_victim_valid          (o_victim_valid),
        .o_victim_dirty          (o_victim_dirty),
        .o_victim_addr           (o_victim_addr),
        .o_victim_data           (o_victim_data)
    );

endmodule

// ==== src/dcache_d1.sv ====
// Data cache hit check and write generation stage
`timescale 1ns/1ps

module dcache_d1 (
    input  logic                     clk,
    input  logic                     n_rst,

    input  logic                     i_req,
    input  logic                     i_wr_en,
    input  dcache_pkg::dc_tag_t      i_tag,
    input  dcache_pkg::dc_index_t    i_index,
    input  dcache_pkg::dc_offset_t   i_offset,
    input  dcache_pkg::dc_byte_sel_t i_byte_sel,
    input  dcache_pkg::dc_data_t     i_data,
    input  logic                     i_valid,
    input  logic                     i_dirty,
    input  logic                     i_fill,
    input  dcache_pkg::dc_line_t     i_fill_data,

    input  logic                     i_cache_rd_valid,
    input  logic                     i_cache_rd_dirty,
    input  dcache_pkg::dc_tag_t      i_cache_rd_tag,
    input  dcache_pkg::dc_line_t     i_cache_rd_data,

    input  logic                     i_bypass_cache_wr_en,
    input  dcache_pkg::dc_index_t    i_bypass_cache_wr_index,
    input  dcache_pkg::dc_tag_t      i_bypass_cache_wr_tag,
    input  dcache_pkg::dc_line_t     i_bypass_cache_wr_data,
    input  logic                     i_bypass_cache_wr_valid,
    input  logic                     i_bypass_cache_wr_dirty,

    output logic                     o_cache_wr_en,
    output dcache_pkg::dc_index_t    o_cache_wr_index,
    output dcache_pkg::dc_tag_t      o_cache_wr_tag,
    output dcache_pkg::dc_line_t     o_cache_wr_data,
    output logic                     o_cache_wr_valid,
    output logic                     o_cache_wr_dirty,

    output logic                     o_ack,
    output logic                     o_hit,
    output dcache_pkg::dc_data_t     o_data,
    output logic                     o_victim_valid,
    output logic                     o_victim_dirty,
    output dcache_pkg::dc_addr_t     o_victim_addr,
    output dcache_pkg::dc_line_t     o_victim_data
);

    import dcache_pkg::*;

    logic     bypass;
    dc_tag_t  line_tag;
    dc_line_t line_data;
    logic     line_valid;
    logic     line_dirty;
    logic     cache_hit;
    dc_data_t rd_word;
    dc_line_t merged_line;
    dc_addr_t victim_addr;

    // Our own write from last cycle has not reached the array yet
    assign bypass     = i_bypass_cache_wr_en & (i_bypass_cache_wr_index == i_index);
    assign line_tag   = bypass ? i_bypass_cache_wr_tag   : i_cache_rd_tag;
    assign line_data  = bypass ? i_bypass_cache_wr_data  : i_cache_rd_data;
    assign line_valid = bypass ? i_bypass_cache_wr_valid : i_cache_rd_valid;
    assign line_dirty = bypass ? i_bypass_cache_wr_dirty : i_cache_rd_dirty;

    assign cache_hit   = line_valid & (line_tag == i_tag);
    assign victim_addr = {line_tag, i_index, {DC_OFFSET_WIDTH{1'b0}}};

    // Load word extraction, bytes that would run past the line end read as zero
    always_comb begin
        int pos;
        rd_word = '0;
        for (int j = 0; j < DC_WORD_SIZE; j++) begin
            pos = int'(i_offset) + j;
            if (i_byte_sel[j] && pos < DC_LINE_SIZE) begin
                rd_word[j*8 +: 8] = line_data[pos*8 +: 8];
            end
        end
    end

    // Store merge at the offset, bytes past the line end are dropped
    always_comb begin
        int pos;
        merged_line = line_data;
        for (int j = 0; j < DC_WORD_SIZE; j++) begin
            pos = int'(i_offset) + j;
            if (i_byte_sel[j] && pos < DC_LINE_SIZE) begin
                merged_line[pos*8 +: 8] = i_data[j*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            o_cache_wr_en <= 1'b0;
            o_ack         <= 1'b0;
        end else begin
            o_cache_wr_en <= i_fill | (i_wr_en & cache_hit);
            o_ack         <= i_req;
        end
    end

    always_ff @(posedge clk) begin
        o_cache_wr_index <= i_index;
        o_cache_wr_tag   <= i_tag;
        o_cache_wr_data  <= i_fill ? i_fill_data : merged_line;
        o_cache_wr_valid <= i_valid;
        o_cache_wr_dirty <= i_dirty;
    end

    // Victim fields describe the line as it stood before this access
    always_ff @(posedge clk) begin
        o_hit          <= cache_hit;
        o_data         <= rd_word;
        o_victim_valid <= line_valid;
        o_victim_dirty <= line_dirty;
        o_victim_addr  <= victim_addr;
        o_victim_data  <= line_data;
    end

    // A fill always writes, and the line it writes is valid and clean
    a_fill_writes: assert property (@(posedge clk) disable iff (~n_rst)
        i_fill |=> (o_cache_wr_en && o_cache_wr_valid && !o_cache_wr_dirty));

endmodule

// ==== src/dcache_array.sv ====
// Data cache tag and line storage
`timescale 1ns/1ps

module dcache_array (
    input  logic                  clk,
    input  logic                  n_rst,

    input  dcache_pkg::dc_index_t i_rd_index,

    input  logic                  i_wr_en,
    input  dcache_pkg::dc_index_t i_wr_index,
    input  dcache_pkg::dc_tag_t   i_wr_tag,
    input  dcache_pkg::dc_line_t  i_wr_data,
    input  logic                  i_wr_valid,
    input  logic                  i_wr_dirty,

    output logic                  o_rd_valid,
    output logic                  o_rd_dirty,
    output dcache_pkg::dc_tag_t   o_rd_tag,
    output dcache_pkg::dc_line_t  o_rd_data
);

    import dcache_pkg::*;

    logic [DC_NUM_SETS-1:0] valid_q;
    logic [DC_NUM_SETS-1:0] dirty_q;
    dc_tag_t                tag_mem  [DC_NUM_SETS];
    dc_line_t               line_mem [DC_NUM_SETS];
    logic                   fwd;

    // Write first, a same-edge write to the read set is seen by the read
    assign fwd = i_wr_en & (i_wr_index == i_rd_index);

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            valid_q    <= '0;
            dirty_q    <= '0;
            o_rd_valid <= 1'b0;
            o_rd_dirty <= 1'b0;
        end else begin
            if (i_wr_en) begin
                valid_q[i_wr_index] <= i_wr_valid;
                dirty_q[i_wr_index] <= i_wr_dirty;
            end
            o_rd_valid <= fwd ? i_wr_valid : valid_q[i_rd_index];
            o_rd_dirty <= fwd ? i_wr_dirty : dirty_q[i_rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            tag_mem[i_wr_index]  <= i_wr_tag;
            line_mem[i_wr_index] <= i_wr_data;
        end
        o_rd_tag  <= fwd ? i_wr_tag  : tag_mem[i_rd_index];
        o_rd_data <= fwd ? i_wr_data : line_mem[i_rd_index];
    end

    a_wr_index_known: assert property (@(posedge clk) disable iff (~n_rst)
        i_wr_en |-> !$isunknown(i_wr_index));

endmodule

// ==== src/dcache_d0.sv ====
// Data cache request decode stage
`timescale 1ns/1ps

module dcache_d0 (
    input  logic                    clk,
    input  logic                    n_rst,

    input  logic                    i_req,
    input  dcache_pkg::dc_op_t      i_op,
    input  dcache_pkg::dc_addr_t    i_addr,
    input  dcache_pkg::dc_byte_sel_t i_byte_sel,
    input  dcache_pkg::dc_data_t    i_data,
    input  dcache_pkg::dc_line_t    i_fill_data,

    output dcache_pkg::dc_index_t   o_rd_index,

    output logic                    o_req,
    output logic                    o_wr_en,
    output logic                    o_fill,
    output dcache_pkg::dc_tag_t     o_tag,
    output dcache_pkg::dc_index_t   o_index,
    output dcache_pkg::dc_offset_t  o_offset,
    output dcache_pkg::dc_byte_sel_t o_byte_sel,
    output dcache_pkg::dc_data_t    o_data,
    output logic                    o_valid,
    output logic                    o_dirty,
    output dcache_pkg::dc_line_t    o_fill_data
);

    import dcache_pkg::*;

    dc_tag_t    addr_tag;
    dc_index_t  addr_index;
    dc_offset_t addr_offset;
    logic       store;
    logic       fill;

    assign addr_tag    = i_addr[DC_ADDR_WIDTH-1 -: DC_TAG_WIDTH];
    assign addr_index  = i_addr[DC_OFFSET_WIDTH +: DC_INDEX_WIDTH];
    assign addr_offset = i_addr[DC_OFFSET_WIDTH-1:0];

    // The array read starts in the same cycle as the request
    assign o_rd_index = i_req ? addr_index : '0;

    assign store = i_req & (i_op == DC_OP_STORE);
    assign fill  = i_req & (i_op == DC_OP_FILL);

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            o_req   <= 1'b0;
            o_wr_en <= 1'b0;
            o_fill  <= 1'b0;
        end else begin
            o_req   <= i_req;
            o_wr_en <= store;
            o_fill  <= fill;
        end
    end

    // Stores leave the line dirty, fills bring it in clean
    always_ff @(posedge clk) begin
        o_tag       <= addr_tag;
        o_index     <= addr_index;
        o_offset    <= addr_offset;
        o_byte_sel  <= i_byte_sel;
        o_data      <= i_data;
        o_valid     <= store | fill;
        o_dirty     <= store;
        o_fill_data <= i_fill_data;
    end

    // Every request carries one defined opcode, so a fill never decodes as a store too
    a_fill_not_store: assert property (@(posedge clk) disable iff (~n_rst)
        i_req |-> (i_op inside {DC_OP_LOAD, DC_OP_STORE, DC_OP_FILL}));

endmodule

// ==== src/dcache_pkg.sv ====
// Data cache shared definitions
package dcache_pkg;

    // Cache geometry, direct mapped with 16 byte lines
    localparam int DC_ADDR_WIDTH   = 32;
    localparam int DC_DATA_WIDTH   = 32;
    localparam int DC_WORD_SIZE    = 4;
    localparam int DC_LINE_SIZE    = 16;
    localparam int DC_OFFSET_WIDTH = 4;
    localparam int DC_INDEX_WIDTH  = 4;
    localparam int DC_TAG_WIDTH    = 24;
    localparam int DC_LINE_WIDTH   = DC_LINE_SIZE * 8;
    localparam int DC_NUM_SETS     = 1 << DC_INDEX_WIDTH;

    // Address fields
    typedef logic [DC_ADDR_WIDTH-1:0]   dc_addr_t;
    typedef logic [DC_TAG_WIDTH-1:0]    dc_tag_t;
    typedef logic [DC_INDEX_WIDTH-1:0]  dc_index_t;
    typedef logic [DC_OFFSET_WIDTH-1:0] dc_offset_t;

    // Bit j enables byte j of the word
    typedef logic [DC_WORD_SIZE-1:0]    dc_byte_sel_t;

    // Data word and line, byte k of a line sits at bits 8k and up
    typedef logic [DC_DATA_WIDTH-1:0]   dc_data_t;
    typedef logic [DC_LINE_WIDTH-1:0]   dc_line_t;

    // Request opcodes
    typedef enum logic [1:0] {
        DC_OP_LOAD  = 2'b00,
        DC_OP_STORE = 2'b01,
        DC_OP_FILL  = 2'b10
    } dc_op_t;

endpackage
